/* build.f */
common/mem_pkg.sv
mem_stage/mem_stage.sv
hdl/data_ram.sv
hdl/wb_stage.sv
hdl/mem_subsys_top.sv
verif/clk_gen.sv
verif/tb_mem_subsys.sv

/* common/mem_pkg.sv */
package mem_pkg;

  // data and address width
  localparam int xlen = 64;

  typedef enum logic [3:0] {
    op_none = 4'd0,
    op_lb   = 4'd1,
    op_lh   = 4'd2,
    op_lw   = 4'd3,
    op_ld   = 4'd4,
    op_lbu  = 4'd5,
    op_lhu  = 4'd6,
    op_lwu  = 4'd7,
    op_sb   = 4'd8,
    op_sh   = 4'd9,
    op_sw   = 4'd10,
    op_sd   = 4'd11
  } mem_op_e;

  typedef enum logic [1:0] {
    size_b = 2'd0,
    size_h = 2'd1,
    size_w = 2'd2,
    size_d = 2'd3
  } mem_size_e;

  typedef enum logic [1:0] {
    wb_alu  = 2'd0,
    wb_load = 2'd1,
    wb_csr  = 2'd2
  } wb_sel_e;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_addr = 2'd1,
    st_retn = 2'd2
  } mem_state_e;

  // addr doubles as the alu result for non-memory ops
  typedef struct packed {
    logic [xlen-1:0] pc;
    mem_op_e         op;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] store_data;
    logic [xlen-1:0] csr_data;
    logic [4:0]      rd;
    logic            rd_we;
    wb_sel_e         wb_sel;
  } ex_to_mem_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic            rd_we;
    wb_sel_e         wb_sel;
    logic [xlen-1:0] ex_result;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] csr_data;
  } mem_to_wb_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            rd_we;
    logic [xlen-1:0] ex_result;
    wb_sel_e         wb_sel;
  } mem_forward_t;

  // wdata is low-aligned
  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            write;
    mem_size_e       size;
  } ram_req_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [4:0]      rd;
    logic            we;
    logic [xlen-1:0] data;
  } commit_t;

endpackage

/* hdl/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
  parameter int RAM_WORDS = 64,
  parameter int RAM_WAIT  = 2
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     rw_valid,
  input  mem_pkg::ram_req_t        rw_req,
  output logic                     rw_ready,
  output logic [mem_pkg::xlen-1:0] r_data
);
  import mem_pkg::*;

  localparam int idx_w = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int cnt_w = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

  logic [xlen-1:0]  mem [RAM_WORDS];
  logic [cnt_w-1:0] wait_cnt;
  logic [idx_w-1:0] idx;
  logic [2:0]       offset;
  logic [7:0]       size_lanes;
  logic [7:0]       lane_en;
  logic [2:0]       align_mask;
  logic [xlen-1:0]  wdata_sh;

  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // counts the cycles of an outstanding request
  always_ff @(posedge clk) begin
    if (rst || !rw_valid || rw_ready) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign rw_ready = rw_valid && (wait_cnt == cnt_w'(RAM_WAIT));

  assign idx    = rw_req.addr[idx_w+2:3];
  assign offset = rw_req.addr[2:0];

  always_comb begin
    case (rw_req.size)
      size_b: begin
        size_lanes = 8'h01;
        align_mask = 3'b000;
      end
      size_h: begin
        size_lanes = 8'h03;
        align_mask = 3'b001;
      end
      size_w: begin
        size_lanes = 8'h0f;
        align_mask = 3'b011;
      end
      default: begin
        size_lanes = 8'hff;
        align_mask = 3'b111;
      end
    endcase
  end

  assign lane_en  = size_lanes << offset;
  assign wdata_sh = rw_req.wdata << {offset, 3'b000};

  always_ff @(posedge clk) begin
    if (rw_valid && rw_ready && rw_req.write) begin
      for (int b = 0; b < 8; b++) begin
        if (lane_en[b]) begin
          mem[idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
        end
      end
    end
  end

  // addressed bytes land at bit 0
  assign r_data = mem[idx] >> {offset, 3'b000};

  assert property (@(posedge clk) disable iff (rst)
    rw_valid |-> ((offset & align_mask) == 3'b000)
                 && ((rw_req.addr >> 3) < xlen'(RAM_WORDS)));

endmodule

/* hdl/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int RAM_WORDS = 64,
  parameter int RAM_WAIT  = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  ex_valid,
  input  mem_pkg::ex_to_mem_t   ex_bus,
  output logic                  mem_allowin,
  output mem_pkg::mem_forward_t fwd,
  output logic                  commit_valid,
  output mem_pkg::commit_t      commit,
  input  logic                  commit_ready
);
  import mem_pkg::*;

  logic            mem_to_wb_valid;
  mem_to_wb_t      mem_to_wb;
  logic            wb_allowin;
  logic            rw_valid;
  ram_req_t        rw_req;
  logic            rw_ready;
  logic [xlen-1:0] r_data;

  mem_stage u_mem_stage (
    .clk, .rst, .ex_valid, .ex_bus, .mem_allowin,
    .mem_to_wb_valid, .mem_to_wb, .wb_allowin, .fwd,
    .rw_valid, .rw_req, .rw_ready, .r_data
  );

  data_ram #(
    .RAM_WORDS (RAM_WORDS),
    .RAM_WAIT  (RAM_WAIT)
  ) u_data_ram (
    .clk, .rst, .rw_valid, .rw_req, .rw_ready, .r_data
  );

  wb_stage u_wb_stage (
    .clk, .rst, .mem_to_wb_valid, .mem_to_wb, .wb_allowin,
    .commit_valid, .commit, .commit_ready
  );

endmodule

/* hdl/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                mem_to_wb_valid,
  input  mem_pkg::mem_to_wb_t mem_to_wb,
  output logic                wb_allowin,
  output logic                commit_valid,
  output mem_pkg::commit_t    commit,
  input  logic                commit_ready
);
  import mem_pkg::*;

  logic            wb_valid;
  logic [xlen-1:0] sel_data;

  assign wb_allowin   = !wb_valid || commit_ready;
  assign commit_valid = wb_valid;

  always_comb begin
    case (mem_to_wb.wb_sel)
      wb_load: sel_data = mem_to_wb.load_data;
      wb_csr:  sel_data = mem_to_wb.csr_data;
      default: sel_data = mem_to_wb.ex_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= mem_to_wb_valid;
    end
  end

  // x0 is never written
  always_ff @(posedge clk) begin
    if (mem_to_wb_valid && wb_allowin) begin
      commit.pc   <= mem_to_wb.pc;
      commit.rd   <= mem_to_wb.rd;
      commit.we   <= mem_to_wb.rd_we && (mem_to_wb.rd != 5'd0);
      commit.data <= sel_data;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    commit_valid && !commit_ready |=> commit_valid && $stable(commit));

endmodule

/* mem_stage/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     ex_valid,
  input  mem_pkg::ex_to_mem_t      ex_bus,
  output logic                     mem_allowin,
  output logic                     mem_to_wb_valid,
  output mem_pkg::mem_to_wb_t      mem_to_wb,
  input  logic                     wb_allowin,
  output mem_pkg::mem_forward_t    fwd,
  output logic                     rw_valid,
  output mem_pkg::ram_req_t        rw_req,
  input  logic                     rw_ready,
  input  logic [mem_pkg::xlen-1:0] r_data
);
  import mem_pkg::*;

  logic            mem_valid;
  logic            ready_go;
  logic            accept;
  logic            req_done;
  ex_to_mem_t      held;
  mem_state_e      state;
  mem_state_e      state_nxt;
  mem_size_e       size;
  logic [xlen-1:0] size_mask;
  logic [xlen-1:0] load_data;

  assign accept          = ex_valid && mem_allowin;
  assign req_done        = rw_valid && rw_ready;
  assign ready_go        = (held.op == op_none) || (state == st_retn);
  assign mem_allowin     = !mem_valid || (ready_go && wb_allowin);
  assign mem_to_wb_valid = mem_valid && ready_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held <= ex_bus;
    end
  end

  // one request per memory op, retn releases the item
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (accept && ex_bus.op != op_none) begin
          state_nxt = st_addr;
        end
      end
      st_addr: begin
        if (req_done) begin
          state_nxt = st_retn;
        end
      end
      st_retn: begin
        if (mem_allowin) begin
          state_nxt = (accept && ex_bus.op != op_none) ? st_addr : st_idle;
        end
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_comb begin
    case (held.op)
      op_lb, op_lbu, op_sb: size = size_b;
      op_lh, op_lhu, op_sh: size = size_h;
      op_lw, op_lwu, op_sw: size = size_w;
      default:              size = size_d;
    endcase
    case (size)
      size_b:  size_mask = 64'h0000_0000_0000_00ff;
      size_h:  size_mask = 64'h0000_0000_0000_ffff;
      size_w:  size_mask = 64'h0000_0000_ffff_ffff;
      default: size_mask = '1;
    endcase
  end

  assign rw_valid     = (state == st_addr);
  assign rw_req.addr  = held.addr;
  assign rw_req.wdata = held.store_data & size_mask;
  assign rw_req.write = held.op inside {op_sb, op_sh, op_sw, op_sd};
  assign rw_req.size  = size;

  // stores leave zero behind
  always_ff @(posedge clk) begin
    if (req_done) begin
      case (held.op)
        op_lb:   load_data <= {{56{r_data[7]}}, r_data[7:0]};
        op_lh:   load_data <= {{48{r_data[15]}}, r_data[15:0]};
        op_lw:   load_data <= {{32{r_data[31]}}, r_data[31:0]};
        op_ld:   load_data <= r_data;
        op_lbu:  load_data <= {56'b0, r_data[7:0]};
        op_lhu:  load_data <= {48'b0, r_data[15:0]};
        op_lwu:  load_data <= {32'b0, r_data[31:0]};
        default: load_data <= '0;
      endcase
    end
  end

  assign mem_to_wb.pc        = held.pc;
  assign mem_to_wb.rd        = held.rd;
  assign mem_to_wb.rd_we     = held.rd_we;
  assign mem_to_wb.wb_sel    = held.wb_sel;
  assign mem_to_wb.ex_result = held.addr;
  assign mem_to_wb.load_data = load_data;
  assign mem_to_wb.csr_data  = held.csr_data;

  assign fwd.rd        = held.rd;
  assign fwd.rd_we     = held.rd_we && mem_valid;
  assign fwd.ex_result = held.addr;
  assign fwd.wb_sel    = held.wb_sel;

  // request must hold until the RAM takes it
  assert property (@(posedge clk) disable iff (rst)
    rw_valid && !rw_ready |=> rw_valid && $stable(rw_req));

  assert property (@(posedge clk) disable iff (rst)
    rw_valid |-> mem_valid && held.op != op_none);

endmodule

/* verif/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 8,
  parameter int RST_DELAY  = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release just after an edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #RST_DELAY rst = 1'b0;
  end

endmodule

/* verif/tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;
  import mem_pkg::*;

  localparam int RAM_WORDS   = 64;
  localparam int RAM_WAIT    = 3;
  localparam int N_OPS       = 400;
  localparam int SEED        = 99311;
  localparam int DRIVE_DELAY = 5;

  typedef struct packed {
    commit_t         c;
    logic            rd_we;
    logic [xlen-1:0] ex_result;
    wb_sel_e         wb_sel;
  } expect_t;

  logic         clk;
  logic         rst;
  logic         ex_valid;
  ex_to_mem_t   ex_bus;
  logic         mem_allowin;
  mem_forward_t fwd;
  logic         commit_valid;
  commit_t      commit;
  logic         commit_ready;

  logic [7:0] model_mem [RAM_WORDS*8];
  expect_t    exp_q [$];
  logic       hold_pending = 1'b0;
  commit_t    held_commit;
  int         n_commits = 0;

  clk_gen #(.PERIOD(40), .RST_CYCLES(8), .RST_DELAY(DRIVE_DELAY)) u_clk_gen (
    .clk, .rst
  );

  mem_subsys_top #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT)) UUT (
    .clk, .rst, .ex_valid, .ex_bus, .mem_allowin, .fwd,
    .commit_valid, .commit, .commit_ready
  );

  task automatic fail_stop();
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  function automatic int op_bytes(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      op_ld, op_sd:         return 8;
      default:              return 0;
    endcase
  endfunction

  function automatic logic [63:0] load_value(input mem_op_e op, input logic [63:0] addr);
    logic [63:0] raw;
    int          base;
    raw  = '0;
    base = int'(addr[15:0]);
    for (int k = 0; k < op_bytes(op); k++) begin
      raw[k*8 +: 8] = model_mem[base + k];
    end
    case (op)
      op_lb:   return {{56{raw[7]}}, raw[7:0]};
      op_lh:   return {{48{raw[15]}}, raw[15:0]};
      op_lw:   return {{32{raw[31]}}, raw[31:0]};
      op_ld, op_lbu, op_lhu, op_lwu: return raw;
      default: return '0;
    endcase
  endfunction

  function automatic expect_t build_expect(input ex_to_mem_t op);
    expect_t e;
    e.c.pc      = op.pc;
    e.c.rd      = op.rd;
    e.c.we      = op.rd_we && (op.rd != 5'd0);
    e.rd_we     = op.rd_we;
    e.ex_result = op.addr;
    e.wb_sel    = op.wb_sel;
    case (op.wb_sel)
      wb_load: e.c.data = load_value(op.op, op.addr);
      wb_csr:  e.c.data = op.csr_data;
      default: e.c.data = op.addr;
    endcase
    return e;
  endfunction

  task automatic apply_store(input ex_to_mem_t op);
    int base;
    base = int'(op.addr[15:0]);
    if (op.op inside {op_sb, op_sh, op_sw, op_sd}) begin
      for (int k = 0; k < op_bytes(op.op); k++) begin
        model_mem[base + k] = op.store_data[k*8 +: 8];
      end
    end
  endtask

  function automatic bit in_flight(input logic [4:0] rd, input logic [63:0] result,
                                   input wb_sel_e sel);
    foreach (exp_q[i]) begin
      if (exp_q[i].rd_we && exp_q[i].c.rd == rd && exp_q[i].ex_result == result
          && exp_q[i].wb_sel == sel) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic make_op(input int n, output ex_to_mem_t op);
    int         kind;
    int         idx;
    logic [2:0] off;
    kind          = $urandom_range(0, 2);
    op.pc         = 64'h8000_0000 + 64'(n) * 4;
    op.store_data = {$urandom, $urandom};
    op.csr_data   = {$urandom, $urandom};
    op.rd         = 5'($urandom);
    op.rd_we      = ($urandom_range(0, 3) != 0);
    case (kind)
      0:       op.op = op_none;
      1:       op.op = mem_op_e'($urandom_range(1, 7));
      default: op.op = mem_op_e'($urandom_range(8, 11));
    endcase
    if (op.op == op_none) begin
      op.addr   = {$urandom, $urandom};
      op.wb_sel = ($urandom_range(0, 1) != 0) ? wb_csr : wb_alu;
    end else begin
      // mostly the low words, so loads see earlier stores
      idx       = ($urandom_range(0, 3) == 0) ? $urandom_range(0, RAM_WORDS - 1)
                                              : $urandom_range(0, 7);
      off       = 3'($urandom_range(0, 7)) & ~3'(op_bytes(op.op) - 1);
      op.addr   = (64'(idx) << 3) | 64'(off);
      op.wb_sel = wb_sel_e'($urandom_range(0, 2));
    end
  endtask

  always @(posedge clk) begin
    expect_t head;
    if (!rst) begin
      if (fwd.rd_we) begin
        assert (in_flight(fwd.rd, fwd.ex_result, fwd.wb_sel)) else begin
          $display("fwd at %0t shows rd %0d result %h wb_sel %0d, which matches no op in flight",
                   $time, fwd.rd, fwd.ex_result, fwd.wb_sel);
          fail_stop();
        end
      end
      if (hold_pending) begin
        assert (commit_valid === 1'b1 && commit === held_commit) else begin
          $display("Fail at %0t: held commit is %h (valid %b), expected %h",
                   $time, commit, commit_valid, held_commit);
          fail_stop();
        end
      end
      hold_pending = commit_valid && !commit_ready;
      held_commit  = commit;
      if (commit_valid && commit_ready) begin
        assert (exp_q.size() > 0) else begin
          $display("commit of pc %h at %0t has no accepted op behind it", commit.pc, $time);
          fail_stop();
        end
        head = exp_q.pop_front();
        check_value("commit.pc", commit.pc, head.c.pc);
        check_value("commit.rd", 64'(commit.rd), 64'(head.c.rd));
        check_value("commit.we", 64'(commit.we), 64'(head.c.we));
        check_value("commit.data", commit.data, head.c.data);
        n_commits++;
      end
      if (ex_valid && mem_allowin) begin
        exp_q.push_back(build_expect(ex_bus));
        apply_store(ex_bus);
      end
    end
  end

  initial begin
    repeat (N_OPS * (RAM_WAIT + 40)) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", N_OPS * (RAM_WAIT + 40));
    fail_stop();
  end

  initial begin
    ex_to_mem_t  cur;
    int          sent;
    int unsigned seed_ret;
    seed_ret     = $urandom(SEED);
    ex_valid     = 1'b0;
    ex_bus       = '0;
    commit_ready = 1'b0;
    foreach (model_mem[i]) begin
      model_mem[i] = 8'h00;
    end

    do begin
      @(posedge clk);
    end while (rst);
    check_value("commit_valid", 64'(commit_valid), 64'd0);
    check_value("mem_allowin", 64'(mem_allowin), 64'd1);

    make_op(0, cur);
    sent = 0;
    while (sent < N_OPS) begin
      @(posedge clk);
      if (ex_valid && mem_allowin) begin
        sent++;
        make_op(sent, cur);
      end
      #DRIVE_DELAY;
      if ($urandom_range(0, 3) == 0) begin
        commit_ready = !commit_ready;
      end
      ex_valid = (sent < N_OPS) && ($urandom_range(0, 3) != 0);
      ex_bus   = cur;
    end

    // drain what is still in flight
    do begin
      @(posedge clk);
      #DRIVE_DELAY;
      if ($urandom_range(0, 3) == 0) begin
        commit_ready = !commit_ready;
      end
    end while (exp_q.size() != 0);
    commit_ready = 1'b1;
    repeat (10) @(posedge clk);

    if (exp_q.size() == 0 && n_commits == N_OPS) begin
      $display("%0d ops committed", n_commits);
      $display("Everything OK");
      $finish;
    end else begin
      $display("run ended with %0d commits of %0d ops", n_commits, N_OPS);
      fail_stop();
    end
  end

endmodule
